/* rtl/vga_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// vga package: coordinate, colour and sync types plus
// the colours of the flag of Sweden
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package vga_pkg;

    localparam int cord_w = 10;  // enough for 800 x 525 totals

    typedef logic [cord_w-1:0] cord_t;  // screen coordinate

    // 4 bits per channel, Pmod style
    typedef struct packed {
        logic [3:0] r;  // red
        logic [3:0] g;  // green
        logic [3:0] b;  // blue
    } rgb_t;

    // sync levels for one pixel
    typedef struct packed {
        logic hsync;  // active low
        logic vsync;  // active low
        logic de;     // high in active area
    } sync_t;

    typedef enum logic [1:0] {
        region_border,  // below the flag
        region_cross,   // yellow cross
        region_field    // blue background
    } flag_region_e;

    localparam rgb_t colour_black  = '{r: 4'h0, g: 4'h0, b: 4'h0};
    localparam rgb_t colour_yellow = '{r: 4'hF, g: 4'hC, b: 4'h0};
    localparam rgb_t colour_blue   = '{r: 4'h0, g: 4'h6, b: 4'hA};

endpackage

`default_nettype wire

/* rtl/display_timing.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// display timing: pixel and line counters with
// registered coordinates, sync pulses and data enable
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/1ps

module display_timing #(
    parameter int h_active = 640,  // visible pixels per line
    parameter int h_front  = 16,   // front porch
    parameter int h_sync   = 96,   // sync pulse width
    parameter int h_back   = 48,   // back porch
    parameter int v_active = 480,  // visible lines
    parameter int v_front  = 10,
    parameter int v_sync   = 2,
    parameter int v_back   = 33
) (
    input  logic           clk_pix,
    input  logic           rst_n,
    output vga_pkg::cord_t sx,      // horizontal position
    output vga_pkg::cord_t sy,      // vertical position
    output vga_pkg::sync_t timing   // sync of pixel sx,sy
);

    localparam int h_total = h_active + h_front + h_sync + h_back;
    localparam int v_total = v_active + v_front + v_sync + v_back;

    // window bounds at coordinate width
    localparam vga_pkg::cord_t h_last   = vga_pkg::cord_t'(h_total - 1);
    localparam vga_pkg::cord_t v_last   = vga_pkg::cord_t'(v_total - 1);
    localparam vga_pkg::cord_t h_act    = vga_pkg::cord_t'(h_active);
    localparam vga_pkg::cord_t v_act    = vga_pkg::cord_t'(v_active);
    localparam vga_pkg::cord_t hs_start = vga_pkg::cord_t'(h_active + h_front);
    localparam vga_pkg::cord_t hs_end   = vga_pkg::cord_t'(h_active + h_front + h_sync - 1);
    localparam vga_pkg::cord_t vs_start = vga_pkg::cord_t'(v_active + v_front);
    localparam vga_pkg::cord_t vs_end   = vga_pkg::cord_t'(v_active + v_front + v_sync - 1);

    vga_pkg::cord_t sx_next;  // coordinate of the following pixel
    vga_pkg::cord_t sy_next;

    // sync levels belonging to one coordinate
    function automatic vga_pkg::sync_t sync_at(input vga_pkg::cord_t x,
                                               input vga_pkg::cord_t y);
        vga_pkg::sync_t s;
        s.hsync = ~(x >= hs_start && x <= hs_end);  // negative polarity
        s.vsync = ~(y >= vs_start && y <= vs_end);  // whole lines
        s.de    = (x < h_act) && (y < v_act);
        return s;
    endfunction

    always_comb begin
        if (sx == h_last) begin  // end of line
            sx_next = '0;
            if (sy == v_last) begin  // end of frame
                sy_next = '0;
            end else begin
                sy_next = sy + 1'b1;
            end
        end else begin
            sx_next = sx + 1'b1;
            sy_next = sy;
        end
    end

    // sync registered from the next coordinate so it lines up with sx,sy
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            sx     <= '0;
            sy     <= '0;
            timing <= sync_at('0, '0);  // pixel 0,0 levels
        end else begin
            sx     <= sx_next;
            sy     <= sy_next;
            timing <= sync_at(sx_next, sy_next);
        end
    end

endmodule

`default_nettype wire

/* rtl/flag_painter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// flag painter: region and colour of the
// flag of Sweden at a screen coordinate
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/1ps

module flag_painter #(
    parameter int flag_h   = 400,  // flag height in lines
    parameter int cross_x0 = 200,  // vertical bar, exclusive bounds
    parameter int cross_x1 = 280,
    parameter int cross_y0 = 160,  // horizontal bar, exclusive bounds
    parameter int cross_y1 = 240
) (
    input  vga_pkg::cord_t sx,
    input  vga_pkg::cord_t sy,
    output vga_pkg::rgb_t  colour
);

    localparam vga_pkg::cord_t fh = vga_pkg::cord_t'(flag_h);
    localparam vga_pkg::cord_t cx0 = vga_pkg::cord_t'(cross_x0);
    localparam vga_pkg::cord_t cx1 = vga_pkg::cord_t'(cross_x1);
    localparam vga_pkg::cord_t cy0 = vga_pkg::cord_t'(cross_y0);
    localparam vga_pkg::cord_t cy1 = vga_pkg::cord_t'(cross_y1);

    vga_pkg::flag_region_e region;

    // first match wins
    always_comb begin
        if (sy >= fh) begin
            region = vga_pkg::region_border;  // below the flag
        end else if (sy > cy0 && sy < cy1) begin
            region = vga_pkg::region_cross;   // horizontal bar
        end else if (sx > cx0 && sx < cx1) begin
            region = vga_pkg::region_cross;   // vertical bar
        end else begin
            region = vga_pkg::region_field;
        end
    end

    always_comb begin
        case (region)
            vga_pkg::region_cross: colour = vga_pkg::colour_yellow;
            vga_pkg::region_field: colour = vga_pkg::colour_blue;
            default:               colour = vga_pkg::colour_black;  // border
        endcase
    end

endmodule

`default_nettype wire

/* rtl/vga_output.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// vga output: pin register stage, black in blanking
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/1ps

module vga_output (
    input  logic           clk_pix,
    input  logic           rst_n,
    input  vga_pkg::sync_t timing,     // sync and de of current pixel
    input  vga_pkg::rgb_t  colour,     // painter colour, same pixel
    output logic           vga_hsync,
    output logic           vga_vsync,
    output vga_pkg::rgb_t  vga_rgb
);

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            vga_hsync <= 1'b1;  // inactive level
            vga_vsync <= 1'b1;
            vga_rgb   <= vga_pkg::colour_black;
        end else begin
            vga_hsync <= timing.hsync;
            vga_vsync <= timing.vsync;
            if (timing.de) begin
                vga_rgb <= colour;
            end else begin
                vga_rgb <= vga_pkg::colour_black;  // nothing leaks into blanking
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/flag_display_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// flag display top: 640x480 flag of Sweden
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/1ps

module flag_display_top #(
    parameter int h_active = 640,
    parameter int h_front  = 16,
    parameter int h_sync   = 96,
    parameter int h_back   = 48,
    parameter int v_active = 480,
    parameter int v_front  = 10,
    parameter int v_sync   = 2,
    parameter int v_back   = 33,
    parameter int flag_h   = 400,  // 16:10 flag
    parameter int cross_x0 = 200,
    parameter int cross_x1 = 280,
    parameter int cross_y0 = 160,
    parameter int cross_y1 = 240
) (
    input  logic          clk_pix,    // pixel clock from board PLL
    input  logic          rst_n,
    output logic          vga_hsync,
    output logic          vga_vsync,
    output vga_pkg::rgb_t vga_rgb
);

    vga_pkg::cord_t sx;
    vga_pkg::cord_t sy;
    vga_pkg::sync_t timing;  // aligned with sx,sy
    vga_pkg::rgb_t  colour;  // combinational from sx,sy

    display_timing #(
        .h_active(h_active),
        .h_front (h_front),
        .h_sync  (h_sync),
        .h_back  (h_back),
        .v_active(v_active),
        .v_front (v_front),
        .v_sync  (v_sync),
        .v_back  (v_back)
    ) display_timing0 (
        .clk_pix(clk_pix),
        .rst_n  (rst_n),
        .sx     (sx),
        .sy     (sy),
        .timing (timing)
    );

    flag_painter #(
        .flag_h  (flag_h),
        .cross_x0(cross_x0),
        .cross_x1(cross_x1),
        .cross_y0(cross_y0),
        .cross_y1(cross_y1)
    ) flag_painter0 (
        .sx    (sx),
        .sy    (sy),
        .colour(colour)
    );

    // one register to the pins
    vga_output vga_output0 (
        .clk_pix  (clk_pix),
        .rst_n    (rst_n),
        .timing   (timing),
        .colour   (colour),
        .vga_hsync(vga_hsync),
        .vga_vsync(vga_vsync),
        .vga_rgb  (vga_rgb)
    );

endmodule

`default_nettype wire

/* test/tb_clock.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench clock: 100 ns pixel clock and
// active low reset held for a few cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/1ps

module tb_clock #(
    parameter int reset_cycles = 4  // edges with rst_n low
) (
    output logic clk_pix,
    output logic rst_n
);

    initial begin
        clk_pix = 1'b0;
        forever #50 clk_pix = ~clk_pix;  // 100 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk_pix);
        #1 rst_n = 1'b1;  // just after the edge
    end

endmodule

`default_nettype wire

/* test/tb_flag_display.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// flag display testbench: directed tests of reset,
// sync timing and the colour of every pixel in a frame
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/1ps

module tb_flag_display;

    // shrunk display so a frame is only 4320 cycles
    localparam int h_active = 64;
    localparam int h_front  = 4;
    localparam int h_sync   = 8;
    localparam int h_back   = 4;
    localparam int v_active = 48;
    localparam int v_front  = 2;
    localparam int v_sync   = 2;
    localparam int v_back   = 2;
    localparam int flag_h   = 40;
    localparam int cross_x0 = 20;
    localparam int cross_x1 = 28;
    localparam int cross_y0 = 16;
    localparam int cross_y1 = 24;

    localparam int h_total = h_active + h_front + h_sync + h_back;  // 80
    localparam int v_total = v_active + v_front + v_sync + v_back;  // 54
    localparam int frame_cycles = h_total * v_total;
    localparam int hs_start = h_active + h_front;
    localparam int vs_start = v_active + v_front;  // line of the vsync fall

    logic          clk_pix;
    logic          rst_n;
    logic          vga_hsync;
    logic          vga_vsync;
    vga_pkg::rgb_t vga_rgb;

    tb_clock #(.reset_cycles(4)) tb_clock0 (
        .clk_pix(clk_pix),
        .rst_n  (rst_n)
    );

    flag_display_top #(
        .h_active(h_active), .h_front(h_front), .h_sync(h_sync), .h_back(h_back),
        .v_active(v_active), .v_front(v_front), .v_sync(v_sync), .v_back(v_back),
        .flag_h  (flag_h),
        .cross_x0(cross_x0), .cross_x1(cross_x1),
        .cross_y0(cross_y0), .cross_y1(cross_y1)
    ) dut0 (
        .clk_pix  (clk_pix),
        .rst_n    (rst_n),
        .vga_hsync(vga_hsync),
        .vga_vsync(vga_vsync),
        .vga_rgb  (vga_rgb)
    );

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("FAIL: see errors above");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(input string name, input logic [11:0] expected,
                               input logic [11:0] actual);
        assert (actual === expected) else
            report_failure($sformatf("Error: time %0t: %s expected %h, got %h",
                                     $time, name, expected, actual));
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        assert (actual == expected) else
            report_failure($sformatf("Error: time %0t: %s expected %0d, got %0d",
                                     $time, name, expected, actual));
    endtask

    // outputs settle well before the next edge
    task automatic next_cycle();
        @(posedge clk_pix);
        #10;
    endtask

    function automatic logic expected_hsync(input int x);
        return !(x >= hs_start && x < hs_start + h_sync);  // low in sync window
    endfunction

    function automatic logic expected_vsync(input int y);
        return !(y >= vs_start && y < vs_start + v_sync);
    endfunction

    // ordered region rule, black outside the active area
    function automatic vga_pkg::rgb_t expected_colour(input int x, input int y);
        if (!(x < h_active && y < v_active)) return vga_pkg::colour_black;
        if (y >= flag_h) return vga_pkg::colour_black;            // border
        if (y > cross_y0 && y < cross_y1) return vga_pkg::colour_yellow;
        if (x > cross_x0 && x < cross_x1) return vga_pkg::colour_yellow;
        return vga_pkg::colour_blue;                              // field
    endfunction

    task automatic step_model(inout int x, inout int y);
        x++;
        if (x == h_total) begin  // wrap line
            x = 0;
            y = (y == v_total - 1) ? 0 : y + 1;
        end
    endtask

    function automatic logic sync_level(input bit vertical);
        return vertical ? vga_vsync : vga_hsync;
    endfunction

    // stops on a sample where the chosen sync has just gone low
    task automatic wait_sync_fall(input bit vertical, input int limit, output int cycles);
        logic prev;
        cycles = 0;
        prev = sync_level(vertical);
        next_cycle();
        cycles++;
        while (!(prev === 1'b1 && sync_level(vertical) === 1'b0)) begin
            if (cycles > limit)
                report_failure($sformatf("%s did not fall within %0d cycles",
                                         vertical ? "vga_vsync" : "vga_hsync", limit));
            prev = sync_level(vertical);
            next_cycle();
            cycles++;
        end
    endtask

    // low length, then cycles up to the next fall
    task automatic measure_sync(input bit vertical, input int exp_low, input int exp_period);
        int low;
        int rest;
        low = 0;
        while (sync_level(vertical) === 1'b0) begin
            low++;
            if (low > exp_period)
                report_failure("sync stayed low for longer than a whole period");
            next_cycle();
        end
        check_count(vertical ? "vsync low cycles" : "hsync low cycles", exp_low, low);
        wait_sync_fall(vertical, 2 * exp_period, rest);
        check_count(vertical ? "frame period" : "line period", exp_period, low + rest);
    endtask

    task automatic test_reset_state();
        int guard;
        guard = 0;
        next_cycle();
        while (!rst_n) begin
            check_value("vga_hsync", 12'(1), 12'(vga_hsync));
            check_value("vga_vsync", 12'(1), 12'(vga_vsync));
            check_value("vga_rgb", vga_pkg::colour_black, vga_rgb);
            guard++;
            if (guard > 20) report_failure("reset was never released");
            next_cycle();
        end
        check_value("vga_rgb", vga_pkg::colour_black, vga_rgb);  // no edge since release
        next_cycle();
        check_value("vga_hsync", 12'(expected_hsync(0)), 12'(vga_hsync));
        check_value("vga_vsync", 12'(expected_vsync(0)), 12'(vga_vsync));
        check_value("vga_rgb", expected_colour(0, 0), vga_rgb);  // pixel 0,0
        $display("reset state test done");
    endtask

    task automatic test_horizontal_timing();
        int n;
        wait_sync_fall(1'b0, 2 * h_total, n);
        repeat (3) measure_sync(1'b0, h_sync, h_total);
        $display("horizontal timing test done");
    endtask

    task automatic test_vertical_timing();
        int n;
        wait_sync_fall(1'b1, 2 * frame_cycles, n);
        repeat (2) measure_sync(1'b1, v_sync * h_total, frame_cycles);
        $display("vertical timing test done");
    endtask

    task automatic test_frame_colour();
        int n;
        int x;
        int y;
        wait_sync_fall(1'b1, 2 * frame_cycles, n);
        x = 0;
        y = vs_start;  // vsync falls at the start of this line
        repeat (frame_cycles) begin
            check_value("vga_rgb", expected_colour(x, y), vga_rgb);
            check_value("vga_hsync", 12'(expected_hsync(x)), 12'(vga_hsync));
            check_value("vga_vsync", 12'(expected_vsync(y)), 12'(vga_vsync));
            step_model(x, y);
            next_cycle();
        end
        $display("full frame colour test done");
    endtask

    task automatic test_blanking_black();
        int n;
        int x;
        int y;
        wait_sync_fall(1'b1, 2 * frame_cycles, n);
        x = 0;
        y = vs_start;
        repeat (frame_cycles) begin
            if (!(x < h_active && y < v_active)) begin
                check_value("vga_rgb", 12'h000, vga_rgb);  // painter may give yellow here
            end
            step_model(x, y);
            next_cycle();
        end
        $display("blanking test done");
    endtask

    initial begin
        test_reset_state();
        test_horizontal_timing();
        test_vertical_timing();
        test_frame_colour();
        test_blanking_black();
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
rtl/vga_pkg.sv
rtl/display_timing.sv
rtl/flag_painter.sv
rtl/vga_output.sv
rtl/flag_display_top.sv
test/tb_clock.sv
test/tb_flag_display.sv

/* Bender.yml */
package:
  name: flag_display

sources:
  - files:
      - rtl/vga_pkg.sv
      - rtl/display_timing.sv
      - rtl/flag_painter.sv
      - rtl/vga_output.sv
      - rtl/flag_display_top.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/tb_flag_display.sv
